// ==== hdl/busArbiter.sv ====
//--------------------------------------
// Bus arbiter
// Fixed priority host, data, fetch onto the
// single-port RAM, one access in flight.
//--------------------------------------

module busArbiter (
    input  logic         clk,
    input  logic         rst,
    memBusIf.slave       hostBus,
    memBusIf.slave       dataBus,
    memBusIf.slave       fetchBus,
    output logic         ramWe,
    output memPkg::addrT ramAddr,
    output memPkg::wordT ramWdata,
    input  memPkg::wordT ramRdata
);
    import memPkg::*;

    portT sel;
    portT grantPort;
    logic busy;
    logic grantNow;
    logic selWe;

    always_comb
    begin
        if (hostBus.req)
            sel = HOST;
        else if (dataBus.req)
            sel = DATA;
        else
            sel = FETCH;
        case (sel)
            HOST:    {selWe, ramAddr, ramWdata} = {hostBus.we, hostBus.addr, hostBus.wdata};
            DATA:    {selWe, ramAddr, ramWdata} = {dataBus.we, dataBus.addr, dataBus.wdata};
            default: {selWe, ramAddr, ramWdata} = {fetchBus.we, fetchBus.addr, fetchBus.wdata};
        endcase
    end

    assign grantNow = !busy && (hostBus.req || dataBus.req || fetchBus.req);
    assign ramWe    = grantNow && selWe;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy      <= 1'b0;
            grantPort <= HOST;
        end
        else
        begin
            busy <= grantNow; // Ack cycle follows every grant.
            if (grantNow)
                grantPort <= sel;
        end
    end

    assign hostBus.ack    = busy && (grantPort == HOST);
    assign dataBus.ack    = busy && (grantPort == DATA);
    assign fetchBus.ack   = busy && (grantPort == FETCH);
    assign hostBus.rdata  = hostBus.ack ? ramRdata : '0;
    assign dataBus.rdata  = dataBus.ack ? ramRdata : '0;
    assign fetchBus.rdata = fetchBus.ack ? ramRdata : '0;

endmodule

// ==== hdl/cpuTop.sv ====
//--------------------------------------
// CPU top
// Core, arbiter and RAM with a plain host port.
//--------------------------------------

module cpuTop (
    input  logic         clk,
    input  logic         rst,
    input  logic         run,
    input  logic         hostReq,
    input  logic         hostWe,
    input  memPkg::addrT hostAddr,
    input  memPkg::wordT hostWdata,
    output memPkg::wordT hostRdata,
    output logic         hostAck,
    output logic         halted
);
    import memPkg::*;

    wordT instr;
    wordT ramWdata;
    wordT ramRdata;
    addrT pc;
    addrT nextPc;
    addrT ramAddr;
    logic instrValid;
    logic done;
    logic ramWe;

    memBusIf fetchBus ();
    memBusIf dataBus ();
    memBusIf hostBus ();

    assign hostBus.req   = hostReq;
    assign hostBus.we    = hostWe;
    assign hostBus.addr  = hostAddr;
    assign hostBus.wdata = hostWdata;
    assign hostRdata     = hostBus.rdata;
    assign hostAck       = hostBus.ack;

    fetchUnit fetch0 (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .bus        (fetchBus.master),
        .nextPc     (nextPc),
        .done       (done),
        .halted     (halted),
        .instr      (instr),
        .pc         (pc),
        .instrValid (instrValid)
    );

    execUnit exec0 (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .pc         (pc),
        .instrValid (instrValid),
        .bus        (dataBus.master),
        .nextPc     (nextPc),
        .done       (done),
        .halted     (halted)
    );

    busArbiter arb0 (
        .clk      (clk),
        .rst      (rst),
        .hostBus  (hostBus.slave),
        .dataBus  (dataBus.slave),
        .fetchBus (fetchBus.slave),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    sharedRam ram0 (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

// ==== hdl/cpu_settings.svh ====
//--------------------------------------
// CPU settings
// Core widths, RAM depth and start address.
//--------------------------------------

`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_XLEN      32
`define CPU_MEM_WORDS 256
`define CPU_ADDR_W    8
`define CPU_RESET_PC  8'd0

`endif

// ==== hdl/decoder.sv ====
//--------------------------------------
// Decoder
// Maps opcode and function to the control word.
//--------------------------------------

module decoder (
    input  isaPkg::opcodeT opCode,
    input  isaPkg::funcT   funcIn,
    output isaPkg::ctrlT   ctrl
);
    import isaPkg::*;

    always_comb
    begin
        ctrl         = '0;
        ctrl.regDst  = RD_RT;
        ctrl.outSel  = OUT_ALU;
        ctrl.funcOut = funcIn;

        case (opCode)
            OP_RTYPE:
                case (funcIn)
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                    FN_NOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA:
                    begin
                        ctrl.regDst   = RD_RD;
                        ctrl.regWrite = 1'b1;
                    end

                    FN_JR:
                    begin
                        ctrl.jump    = 1'b1;
                        ctrl.jumpReg = 1'b1;
                        ctrl.outSel  = OUT_LINK;
                    end

                    default:
                        ctrl.regDst = RD_RD;
                endcase

            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
            begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (opCode)
                    OP_ADDI:  ctrl.funcOut = FN_ADD;
                    OP_ADDIU: ctrl.funcOut = FN_ADDU;
                    OP_SLTI:  ctrl.funcOut = FN_SLT;
                    OP_SLTIU: ctrl.funcOut = FN_SLTU;
                    OP_ANDI:  ctrl.funcOut = FN_AND;
                    OP_ORI:   ctrl.funcOut = FN_OR;
                    OP_XORI:  ctrl.funcOut = FN_XOR;
                    default:  ctrl.funcOut = FN_ADD; // LUI adds to r0.
                endcase
                ctrl.unsgnSel = (opCode == OP_ANDI) || (opCode == OP_ORI) ||
                                (opCode == OP_XORI); // Logic ops zero-extend.
                ctrl.shiftSel = (opCode == OP_LUI);
            end

            OP_BEQ, OP_BNE:
            begin
                ctrl.funcOut  = FN_SUB;
                ctrl.branch   = 1'b1;
                ctrl.branchNe = (opCode == OP_BNE);
                ctrl.outSel   = OUT_LINK;
            end

            OP_J, OP_JAL:
            begin
                ctrl.jump    = 1'b1;
                ctrl.immSize = 1'b1;
                ctrl.outSel  = OUT_LINK;
                if (opCode == OP_JAL)
                begin
                    ctrl.regDst   = RD_R31;
                    ctrl.regWrite = 1'b1;
                end
            end

            OP_LW:
            begin
                ctrl.funcOut  = FN_ADD;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            OP_SW:
            begin
                ctrl.funcOut  = FN_ADD;
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end

            default:
                ctrl.funcOut = funcIn;
        endcase
    end

endmodule

// ==== hdl/execUnit.sv ====
//--------------------------------------
// Execute unit
// Register file, ALU, branch resolution and
// the load/store sequencer.
//--------------------------------------

`include "cpu_settings.svh"

module execUnit (
    input  logic         clk,
    input  logic         rst,
    input  memPkg::wordT instr,
    input  memPkg::addrT pc,
    input  logic         instrValid,
    memBusIf.master      bus,
    output memPkg::addrT nextPc,
    output logic         done,
    output logic         halted
);
    import isaPkg::*;
    import memPkg::*;

    typedef enum logic {EX_IDLE, EX_MEM} exStateT;

    exStateT    state;
    ctrlT       ctrl;
    wordT       regs [32];
    wordT       rsVal;
    wordT       rtVal;
    wordT       extImm;
    wordT       opB;
    wordT       aluResult;
    wordT       wrData;
    logic [4:0] shamt;
    logic [4:0] wrIdx;
    logic       regWe;
    logic       taken;
    logic       dataReq;
    addrT       pcPlus1;
    addrT       branchTarget;
    addrT       jumpTarget;
    addrT       pcNext;

    decoder dec0 (
        .opCode (opcodeT'(instr[31:26])),
        .funcIn (funcT'(instr[5:0])),
        .ctrl   (ctrl)
    );

    assign rsVal = regs[instr[25:21]];
    assign rtVal = regs[instr[20:16]];
    assign shamt = instr[10:6];

    always_comb
    begin
        if (ctrl.immSize)
            extImm = wordT'(instr[25:0]); // Jump index.
        else if (ctrl.unsgnSel)
            extImm = {16'b0, instr[15:0]};
        else
            extImm = {{16{instr[15]}}, instr[15:0]};
    end

    assign opB = !ctrl.aluSrc ? rtVal : (ctrl.shiftSel ? {instr[15:0], 16'b0} : extImm);

    always_comb
    begin
        case (ctrl.funcOut)
            FN_SUB, FN_SUBU: aluResult = rsVal - opB;
            FN_AND:          aluResult = rsVal & opB;
            FN_OR:           aluResult = rsVal | opB;
            FN_XOR:          aluResult = rsVal ^ opB;
            FN_NOR:          aluResult = ~(rsVal | opB);
            FN_SLT:          aluResult = wordT'($signed(rsVal) < $signed(opB));
            FN_SLTU:         aluResult = wordT'(rsVal < opB);
            FN_SLL:          aluResult = opB << shamt;
            FN_SRL:          aluResult = opB >> shamt;
            FN_SRA:          aluResult = $signed(opB) >>> shamt;
            default:         aluResult = rsVal + opB;
        endcase
    end

    // PC values are word addresses; branch offsets count words.
    assign taken        = ctrl.branch && ((aluResult == '0) ^ ctrl.branchNe);
    assign pcPlus1      = pc + 1'b1;
    assign branchTarget = pcPlus1 + addrT'(extImm);
    assign jumpTarget   = ctrl.jumpReg ? addrT'(rsVal) : addrT'(extImm);
    assign pcNext       = ctrl.jump ? jumpTarget : (taken ? branchTarget : pcPlus1);

    always_comb
    begin
        case (ctrl.regDst)
            RD_RT:   wrIdx = instr[20:16];
            RD_RD:   wrIdx = instr[15:11];
            default: wrIdx = 5'd31;
        endcase
        case (ctrl.outSel)
            OUT_LINK: wrData = wordT'(pcPlus1); // Return word address.
            default:  wrData = aluResult;
        endcase
        if (ctrl.memToReg)
            wrData = bus.rdata;
    end

    assign regWe = ctrl.regWrite &&
                   ((state == EX_IDLE && instrValid && !ctrl.memRead) ||
                    (state == EX_MEM && bus.ack));

    // Loads and stores use byte addresses.
    assign bus.req   = dataReq;
    assign bus.we    = (state == EX_MEM) && ctrl.memWrite;
    assign bus.addr  = aluResult[`CPU_ADDR_W+1:2];
    assign bus.wdata = rtVal;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (regWe && wrIdx != 5'd0)
            regs[wrIdx] <= wrData; // r0 stays zero.
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= EX_IDLE;
            dataReq <= 1'b0;
            done    <= 1'b0;
            halted  <= 1'b0;
            nextPc  <= `CPU_RESET_PC;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                EX_IDLE:
                    if (instrValid)
                    begin
                        if (ctrl.memRead || ctrl.memWrite)
                        begin
                            dataReq <= 1'b1;
                            state   <= EX_MEM;
                        end
                        else
                        begin
                            done   <= 1'b1;
                            nextPc <= pcNext;
                            if (ctrl.jump && jumpTarget == pc)
                                halted <= 1'b1; // Self-jump ends the program.
                        end
                    end

                default:
                    if (bus.ack)
                    begin
                        dataReq <= 1'b0;
                        done    <= 1'b1;
                        nextPc  <= pcPlus1;
                        state   <= EX_IDLE;
                    end
            endcase
        end
    end

endmodule

// ==== hdl/fetchUnit.sv ====
//--------------------------------------
// Fetch unit
// Holds the PC, fetches one instruction and
// waits for it to retire.
//--------------------------------------

`include "cpu_settings.svh"

module fetchUnit (
    input  logic         clk,
    input  logic         rst,
    input  logic         run,
    memBusIf.master      bus,
    input  memPkg::addrT nextPc,
    input  logic         done,
    input  logic         halted,
    output memPkg::wordT instr,
    output memPkg::addrT pc,
    output logic         instrValid
);
    import memPkg::*;

    typedef enum logic [1:0] {FE_IDLE, FE_WAIT, FE_EXEC} feStateT;

    feStateT state;
    logic    fetchReq;

    assign bus.req   = fetchReq;
    assign bus.we    = 1'b0; // Read only.
    assign bus.addr  = pc;
    assign bus.wdata = '0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= FE_IDLE;
            pc         <= `CPU_RESET_PC;
            fetchReq   <= 1'b0;
            instrValid <= 1'b0;
        end
        else
        begin
            instrValid <= 1'b0;
            case (state)
                FE_IDLE:
                    if (run && !halted)
                    begin
                        fetchReq <= 1'b1;
                        state    <= FE_WAIT;
                    end

                FE_WAIT:
                    if (bus.ack)
                    begin
                        fetchReq   <= 1'b0;
                        instrValid <= 1'b1;
                        state      <= FE_EXEC;
                    end

                default:
                    if (done)
                    begin
                        pc    <= nextPc;
                        state <= FE_IDLE;
                    end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (bus.ack)
            instr <= bus.rdata; // Held until the next fetch completes.
    end

endmodule

// ==== hdl/isaPkg.sv ====
//--------------------------------------
// ISA package
// Opcode and function encodings, and the
// control word produced by the decoder.
//--------------------------------------

package isaPkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_SLTIU = 6'h0b,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funcT;

    localparam logic [1:0] RD_RT    = 2'd0; // Destination register select.
    localparam logic [1:0] RD_RD    = 2'd1;
    localparam logic [1:0] RD_R31   = 2'd2;
    localparam logic [1:0] OUT_ALU  = 2'd0; // Writeback source select.
    localparam logic [1:0] OUT_LINK = 2'd1;

    typedef struct packed {
        funcT       funcOut;
        logic [1:0] regDst;
        logic [1:0] outSel;
        logic       branch;
        logic       branchNe;
        logic       jump;
        logic       jumpReg;
        logic       memRead;
        logic       memToReg;
        logic       memWrite;
        logic       aluSrc;
        logic       regWrite;
        logic       shiftSel;
        logic       unsgnSel;
        logic       immSize;
    } ctrlT;

endpackage

// ==== hdl/memBusIf.sv ====
//--------------------------------------
// Memory bus
// Level request from a master, one-cycle ack
// with read data from the arbiter.
//--------------------------------------

interface memBusIf;
    import memPkg::*;

    logic req;
    logic we;
    addrT addr;
    wordT wdata;
    wordT rdata; // Valid with ack on reads.
    logic ack;

    modport master (output req, we, addr, wdata, input rdata, ack);

    modport slave (input req, we, addr, wdata, output rdata, ack);

endinterface

// ==== hdl/memPkg.sv ====
//--------------------------------------
// Memory package
// Bus word and address types, arbiter ports.
//--------------------------------------

`include "cpu_settings.svh"

package memPkg;

    typedef logic [`CPU_XLEN-1:0]   wordT;
    typedef logic [`CPU_ADDR_W-1:0] addrT;

    // Listed in priority order.
    typedef enum logic [1:0] {HOST, DATA, FETCH} portT;

endpackage

// ==== hdl/sharedRam.sv ====
//--------------------------------------
// Shared RAM
// Single-port word RAM with registered read.
//--------------------------------------

`include "cpu_settings.svh"

module sharedRam (
    input  logic         clk,
    input  logic         we,
    input  memPkg::addrT addr,
    input  memPkg::wordT wdata,
    output memPkg::wordT rdata
);
    import memPkg::*;

    wordT mem [`CPU_MEM_WORDS];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr]; // Old data on a write cycle.
    end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/isaPkg.sv
hdl/memPkg.sv
hdl/memBusIf.sv
hdl/decoder.sv
hdl/fetchUnit.sv
hdl/execUnit.sv
hdl/busArbiter.sv
hdl/sharedRam.sv
hdl/cpuTop.sv
verif/cpuTb.sv

// ==== verif/cpuTb.sv ====
//--------------------------------------
// CPU testbench
// Loads each program through the host port, runs
// it to the self-jump and reads the results back.
//--------------------------------------

module cpuTb;
    timeunit 1ns;
    timeprecision 100ps;

    import isaPkg::*;
    import memPkg::*;

    localparam int numTests  = 6;
    localparam int progDepth = 40;
    localparam int expDepth  = 16;
    localparam int resBase   = 128; // Result area, word address.
    localparam int resByte   = resBase * 4;
    localparam int resWords  = 16;

    logic clk;
    logic rst;
    logic run;
    logic hostReq;
    logic hostWe;
    addrT hostAddr;
    wordT hostWdata;
    wordT hostRdata;
    logic hostAck;
    logic halted;

    wordT prog [numTests][progDepth];
    int   progLen [numTests];
    int   expSlot [numTests][expDepth];
    wordT expVal [numTests][expDepth];
    int   expLen [numTests];
    bit   pollRun [numTests]; // Host reads the program while the core runs.
    int   cur;
    int   cycles;
    int   cycleLimit;
    int   checkCount;
    int   errorCount;

    cpuTop dut0 (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .hostReq   (hostReq),
        .hostWe    (hostWe),
        .hostAddr  (hostAddr),
        .hostWdata (hostWdata),
        .hostRdata (hostRdata),
        .hostAck   (hostAck),
        .halted    (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic wordT rType(input int rs, input int rt, input int rd, input int sh,
                                   input funcT fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic wordT iType(input opcodeT op, input int rs, input int rt, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic wordT jType(input opcodeT op, input int target);
        return {op, 26'(target)};
    endfunction

    task automatic emit(input wordT w);
        prog[cur][progLen[cur]] = w;
        progLen[cur]++;
    endtask

    task automatic expectSlot(input int slot, input wordT value);
        expSlot[cur][expLen[cur]] = slot;
        expVal[cur][expLen[cur]]  = value;
        expLen[cur]++;
    endtask

    task automatic storeSlot(input int r, input int slot);
        emit(iType(OP_SW, 0, r, resByte + 4 * slot));
    endtask

    // Instruction writes r3, which then goes to the next free slot.
    task automatic storeResult(input wordT w, input wordT value);
        emit(w);
        storeSlot(3, expLen[cur]);
        expectSlot(expLen[cur], value);
    endtask

    task automatic loadConst(input int r, input wordT value);
        emit(iType(OP_LUI, 0, r, value[31:16]));
        emit(iType(OP_ORI, r, r, value[15:0]));
    endtask

    task automatic haltHere();
        emit(jType(OP_J, progLen[cur]));
    endtask

    task automatic buildTable();
        wordT a;
        wordT b;
        int   k;
        a   = 32'h8765_4321;
        b   = 32'h1234_5678;
        cur = 0; // R-type ALU and shifts.
        loadConst(1, a);
        loadConst(2, b);
        storeResult(rType(1, 2, 3, 0, FN_ADD), 32'h9999_9999);
        storeResult(rType(1, 2, 3, 0, FN_ADDU), 32'h9999_9999);
        storeResult(rType(1, 2, 3, 0, FN_SUB), 32'h7530_eca9);
        storeResult(rType(2, 1, 3, 0, FN_SUBU), 32'h8acf_1357);
        storeResult(rType(1, 2, 3, 0, FN_AND), 32'h0224_4220);
        storeResult(rType(1, 2, 3, 0, FN_OR), 32'h9775_5779);
        storeResult(rType(1, 2, 3, 0, FN_XOR), 32'h9551_1559);
        storeResult(rType(1, 2, 3, 0, FN_NOR), 32'h688a_a886);
        storeResult(rType(1, 2, 3, 0, FN_SLT), 32'h1); // a is negative.
        storeResult(rType(1, 2, 3, 0, FN_SLTU), 32'h0);
        storeResult(rType(0, 2, 3, 4, FN_SLL), 32'h2345_6780);
        storeResult(rType(0, 1, 3, 8, FN_SRL), 32'h0087_6543);
        storeResult(rType(0, 1, 3, 8, FN_SRA), 32'hff87_6543);
        haltHere();
        cur = 1; // Immediate forms and extension.
        emit(iType(OP_ORI, 0, 1, 16'h1000));
        emit(iType(OP_ADDI, 0, 2, 16'hffff)); // r2 = -1.
        storeResult(iType(OP_ADDI, 1, 3, 16'hfff0), 32'h0000_0ff0);
        storeResult(iType(OP_ADDIU, 0, 3, 16'h8000), 32'hffff_8000);
        storeResult(iType(OP_ANDI, 2, 3, 16'hff0f), 32'h0000_ff0f);
        storeResult(iType(OP_ORI, 0, 3, 16'h8001), 32'h0000_8001);
        storeResult(iType(OP_XORI, 2, 3, 16'h80ff), 32'hffff_7f00);
        storeResult(iType(OP_LUI, 0, 3, 16'hbeef), 32'hbeef_0000);
        storeResult(iType(OP_SLTI, 2, 3, 16'h0000), 32'h1);
        storeResult(iType(OP_SLTIU, 1, 3, 16'hffff), 32'h1);
        storeResult(iType(OP_ADDI, 2, 3, 16'h0001), 32'h0);
        haltHere();
        cur = 2; // Store, load back, store again.
        loadConst(1, 32'hcafe_f00d);
        emit(iType(OP_ORI, 0, 4, resByte));
        storeSlot(1, 0);
        emit(iType(OP_LW, 4, 2, 0));
        emit(iType(OP_SW, 4, 2, 20));
        haltHere();
        expectSlot(0, 32'hcafe_f00d);
        expectSlot(5, 32'hcafe_f00d);
        cur = 3; // Taken branches skip one marker store.
        emit(iType(OP_ORI, 0, 1, 5));
        emit(iType(OP_ORI, 0, 2, 5));
        emit(iType(OP_ORI, 0, 3, 7));
        emit(iType(OP_ORI, 0, 9, 16'h55));
        emit(iType(OP_BEQ, 1, 2, 1));
        storeSlot(9, 0);
        emit(iType(OP_BEQ, 1, 3, 1));
        storeSlot(9, 1);
        emit(iType(OP_BNE, 1, 3, 1));
        storeSlot(9, 2);
        emit(iType(OP_BNE, 1, 2, 1));
        storeSlot(9, 3);
        haltHere();
        expectSlot(0, 32'h0);
        expectSlot(1, 32'h55);
        expectSlot(2, 32'h0);
        expectSlot(3, 32'h55);
        cur = 4; // Call at word 1, subroutine at word 5.
        emit(iType(OP_ORI, 0, 9, 16'h77));
        emit(jType(OP_JAL, 5));
        storeSlot(31, 0);
        storeSlot(9, 1);
        haltHere();
        emit(iType(OP_ORI, 0, 8, 16'h33));
        storeSlot(8, 2);
        emit(rType(31, 0, 0, 0, FN_JR));
        expectSlot(0, 32'h2);
        expectSlot(1, 32'h77);
        expectSlot(2, 32'h33);
        cur = 5;
        pollRun[cur] = 1'b1;
        emit(iType(OP_ADDI, 0, 3, 1));
        for (k = 0; k < 8; k++)
            storeResult(rType(3, 3, 3, 0, FN_ADDU), wordT'(2) << k);
        haltHere();
    endtask

    // Called 2 ns after a rising edge; returns at the same phase.
    task automatic hostAccess(input logic we, input addrT addr, input wordT wdata,
                              output wordT rdata);
        hostReq   = 1'b1;
        hostWe    = we;
        hostAddr  = addr;
        hostWdata = wdata;
        do
        begin
            @(posedge clk);
            #2;
        end
        while (!hostAck);
        rdata   = hostRdata;
        hostReq = 1'b0;
        hostWe  = 1'b0;
    endtask

    task automatic resetCore();
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    initial
    begin
        cycles = 0;
        while (cycleLimit == 0 || cycles <= cycleLimit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Run did not finish within %0d cycles, halted is %b", cycleLimit, halted);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        int   t;
        int   i;
        int   idx;
        int   totalWords;
        wordT rd;
        rst        = 1'b1;
        run        = 1'b0;
        hostReq    = 1'b0;
        hostWe     = 1'b0;
        hostAddr   = '0;
        hostWdata  = '0;
        checkCount = 0;
        errorCount = 0;
        buildTable();
        totalWords = 0;
        for (t = 0; t < numTests; t++)
            totalWords += progLen[t];
        cycleLimit = totalWords * 20 + 2000;

        for (t = 0; t < numTests; t++)
        begin
            resetCore();
            checkCount++;
            if (halted !== 1'b0)
            begin
                $display("[FAIL] %0t ns: halted after reset expected 0, got %b", $time, halted);
                errorCount++;
            end
            for (i = 0; i < progLen[t]; i++)
                hostAccess(1'b1, addrT'(i), prog[t][i], rd);
            for (i = 0; i < resWords; i++)
                hostAccess(1'b1, addrT'(resBase + i), '0, rd);
            run = 1'b1;
            idx = 0;
            while (!halted)
            begin
                if (pollRun[t])
                begin
                    hostAccess(1'b0, addrT'(idx), '0, rd);
                    checkCount++;
                    if (rd !== prog[t][idx])
                    begin
                        $display("[FAIL] %0t ns: test %0d hostRdata at word %0d expected %h, got %h",
                                 $time, t, idx, prog[t][idx], rd);
                        errorCount++;
                    end
                    idx = (idx + 1) % progLen[t];
                    repeat (3) @(posedge clk); // Leave the RAM to the core.
                    #2;
                end
                else
                begin
                    @(posedge clk);
                    #2;
                end
            end
            run = 1'b0;
            for (i = 0; i < expLen[t]; i++)
            begin
                hostAccess(1'b0, addrT'(resBase + expSlot[t][i]), '0, rd);
                checkCount++;
                if (rd !== expVal[t][i])
                begin
                    $display("[FAIL] %0t ns: test %0d hostRdata at word %0d expected %h, got %h",
                             $time, t, resBase + expSlot[t][i], expVal[t][i], rd);
                    errorCount++;
                end
            end
            checkCount++;
            if (halted !== 1'b1)
            begin
                $display("[FAIL] %0t ns: test %0d halted expected 1, got %b", $time, t, halted);
                errorCount++;
            end
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
